// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_response_engine
RTL_TOP  = response_engine_top
FILELIST = build.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
verilog/engine_pkg.sv
verilog/fifo_pkg.sv
verilog/response_fifo_if.sv
verilog/response_fifo.sv
verilog/response_control.sv
verilog/response_demux.sv
verilog/response_engine_top.sv
testbench/tb_response_engine.sv

// ==== testbench/tb_response_engine.sv ====
// Testbench for the response distribution top level
// Cycle model of FIFO, control and demux with random stimulus

`default_nettype none

module tb_response_engine;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PACKETS    = 300;
  localparam int TIMEOUT_CYCLES = 20 * NUM_PACKETS + 200;

  logic                          ap_clk = 1'b0;
  logic                          areset_control;
  logic                          response_in_valid;
  engine_pkg::response_payload_t response_in_payload;
  engine_pkg::dest_mask_t        receiver_ready;
  engine_pkg::dest_mask_t        response_out_valid;
  engine_pkg::response_payload_t response_out_payload;
  logic                          fifo_full;
  logic                          fifo_prog_full;
  logic                          fifo_empty;
  logic                          fifo_setup;
  integer                        seed;
  int                            cycle_count = 0;
  int                            payload_errors;
  int                            mask_errors;
  int                            flag_errors;
  string                         test_name;

  // Model of the DUT registers
  engine_pkg::response_payload_t model_fifo [$];
  logic                          m_in_valid;
  engine_pkg::response_payload_t m_in_payload;
  engine_pkg::dest_mask_t        m_ready_q;
  logic                          m_pop_valid;
  engine_pkg::response_payload_t m_pop_payload;
  engine_pkg::dest_mask_t        m_out_valid;
  engine_pkg::response_payload_t m_out_payload;
  int                            m_busy;
  logic                          m_running;

  response_engine_top dut_i (
    .ap_clk               (ap_clk),
    .areset_control       (areset_control),
    .response_in_valid    (response_in_valid),
    .response_in_payload  (response_in_payload),
    .receiver_ready       (receiver_ready),
    .response_out_valid   (response_out_valid),
    .response_out_payload (response_out_payload),
    .fifo_full            (fifo_full),
    .fifo_prog_full       (fifo_prog_full),
    .fifo_empty           (fifo_empty),
    .fifo_setup           (fifo_setup)
  );

  always #2 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_payload(input string name, input engine_pkg::response_payload_t expected,
                               input engine_pkg::response_payload_t actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, name, expected, actual);
      payload_errors++;
    end
  endtask

  task automatic check_mask(input string name, input engine_pkg::dest_mask_t expected,
                            input engine_pkg::dest_mask_t actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, name, expected, actual);
      mask_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, name, expected, actual);
      flag_errors++;
    end
  endtask

  // ----------------------------------------
  // Reference model, one rising edge per call
  // ----------------------------------------
  task automatic model_step();
    logic do_rd;
    logic do_wr;
    if (areset_control) begin
      model_fifo.delete();
      m_in_valid  = 1'b0;
      m_ready_q   = '0;
      m_pop_valid = 1'b0;
      m_out_valid = '0;
      m_busy      = fifo_pkg::RST_BUSY_CYCLES;
      m_running   = 1'b0;
    end else begin
      // Pop only when every destined receiver was ready
      do_rd = m_running && (model_fifo.size() != 0) &&
              ((m_ready_q & model_fifo[0].dest) == model_fifo[0].dest);
      do_wr = m_in_valid && (m_in_payload.dest != '0) && m_running &&
              (model_fifo.size() < fifo_pkg::FIFO_DEPTH);
      m_out_valid   = m_pop_valid ? m_pop_payload.dest : '0;
      m_out_payload = m_pop_payload;
      m_pop_valid   = do_rd;
      if (do_rd) m_pop_payload = model_fifo.pop_front();
      if (do_wr) model_fifo.push_back(m_in_payload);
      if (!m_running && m_busy == 0) m_running = 1'b1;
      if (m_busy != 0) m_busy--;
      m_in_valid = response_in_valid;
      m_ready_q  = receiver_ready;
    end
    m_in_payload = response_in_payload;
  endtask

  task automatic step_cycle();
    @(negedge ap_clk);
    model_step();
    check_mask("out_valid", m_out_valid, response_out_valid);
    if (m_out_valid != '0) check_payload("out_payload", m_out_payload, response_out_payload);
    check_flag("fifo_full", model_fifo.size() == fifo_pkg::FIFO_DEPTH, fifo_full);
    check_flag("fifo_prog_full", model_fifo.size() >= fifo_pkg::PROG_THRESH, fifo_prog_full);
    check_flag("fifo_empty", model_fifo.size() == 0, fifo_empty);
    check_flag("fifo_setup", !m_running, fifo_setup);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic make_payload(input logic zero_dest, output engine_pkg::response_payload_t p);
    logic [31:0] r;
    r = $random(seed);
    p.vertex_id = r[15:0];
    r = $random(seed);
    p.data = r;
    p.dest = '0;
    while (!zero_dest && p.dest == '0) begin
      r = $random(seed);
      p.dest = r[3:0];
    end
  endtask

  // Ready mode 0 all ready, 1 random, 2 none; a burst ignores prog_full
  task automatic send_packets(input int num, input int ready_mode, input logic burst);
    int          sent;
    logic [31:0] r;
    sent = 0;
    while (sent < num) begin
      step_cycle();
      r = $random(seed);
      receiver_ready = (ready_mode == 0) ? '1 : (ready_mode == 1) ? (r[3:0] | r[7:4]) : '0;
      if (burst || (!fifo_prog_full && r[9:8] != 2'b00)) begin
        make_payload(!burst && (sent % 10 == 9), response_in_payload);
        response_in_valid = 1'b1;
        sent++;
      end else begin
        response_in_valid = 1'b0;
      end
    end
    step_cycle();
    response_in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (model_fifo.size() != 0 || m_in_valid || m_pop_valid || m_out_valid != '0) begin
      step_cycle();
    end
  endtask

  initial begin
    seed                = 94824;
    payload_errors      = 0;
    mask_errors         = 0;
    flag_errors         = 0;
    areset_control      = 1'b1;
    response_in_valid   = 1'b0;
    response_in_payload = '0;
    receiver_ready      = '0;
    test_name           = "reset";
    repeat (5) step_cycle();
    areset_control = 1'b0;
    test_name = "setup";
    while (fifo_setup) step_cycle();
    test_name = "order_zero_dest";
    send_packets(100, 0, 1'b0);
    wait_drain();
    test_name = "multicast";
    send_packets(184, 1, 1'b0);
    receiver_ready = '1;
    wait_drain();
    test_name = "full_drain";
    receiver_ready = '0;
    repeat (3) step_cycle();
    send_packets(12, 2, 1'b1);
    while (model_fifo.size() < 12) step_cycle();
    check_flag("prog_full at 12", 1'b1, fifo_prog_full);
    check_flag("full at 12", 1'b0, fifo_full);
    send_packets(4, 2, 1'b1);
    while (model_fifo.size() < 16) step_cycle();
    check_flag("full at 16", 1'b1, fifo_full);
    receiver_ready = '1;
    wait_drain();
    check_flag("empty after drain", 1'b1, fifo_empty);
    $display("Errors: payload %0d, mask %0d, flag %0d", payload_errors, mask_errors, flag_errors);
    if (payload_errors + mask_errors + flag_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/engine_pkg.sv ====
// Engine response packet definitions
// Receiver count, destination mask, payload and packet types

`default_nettype none

package engine_pkg;

  // ----------------------------------------
  // Receivers
  // ----------------------------------------

  // Number of response receivers fed by the demux
  localparam int NUM_RECEIVERS = 4;

  // One bit per receiver, bit i selects receiver i
  typedef logic [NUM_RECEIVERS-1:0] dest_mask_t;

  // ----------------------------------------
  // Packets
  // ----------------------------------------

  // Payload as stored in the FIFO, 52 bits
  typedef struct packed {
    logic [15:0] vertex_id;
    logic [31:0] data;
    dest_mask_t  dest;
  } response_payload_t;

  // Payload with its valid strobe
  typedef struct packed {
    logic              valid;
    response_payload_t payload;
  } response_packet_t;

endpackage

`default_nettype wire

// ==== verilog/fifo_pkg.sv ====
// Response FIFO sizing and start-up constants
// Occupancy, pointer and counter types, control phase enum

`default_nettype none

package fifo_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int FIFO_DEPTH      = 16;
  localparam int FIFO_ADDR_W     = 4;
  // Programmable-full at this occupancy or above
  localparam int PROG_THRESH     = 12;
  // Reset-busy length after reset is released
  localparam int RST_BUSY_CYCLES = 4;

  typedef logic [FIFO_ADDR_W:0]   fifo_count_t;
  typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
  typedef logic [2:0]             rst_cnt_t;

  // Control phase, setup while the FIFO is resetting
  typedef enum logic {
    PHASE_SETUP = 1'b0,
    PHASE_RUN   = 1'b1
  } ctrl_phase_t;

endpackage

`default_nettype wire

// ==== verilog/response_control.sv ====
// Response FIFO control
// Setup/run phase, push filtering, ready sampling and pop decision

`default_nettype none

module response_control (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  engine_pkg::dest_mask_t        receiver_ready,
  response_fifo_if.ctrl                 fifo_bus,
  output logic                          pop_valid,
  output engine_pkg::response_payload_t pop_payload,
  output logic                          fifo_setup
);

  fifo_pkg::ctrl_phase_t  phase;
  fifo_pkg::ctrl_phase_t  phase_next;
  engine_pkg::dest_mask_t ready_q;
  engine_pkg::dest_mask_t head_dest;
  logic                   running;
  logic                   all_ready;

  // ----------------------------------------
  // Phase FSM
  // ----------------------------------------
  always_comb begin
    phase_next = phase;
    case (phase)
      fifo_pkg::PHASE_SETUP: if (!fifo_bus.rst_busy) phase_next = fifo_pkg::PHASE_RUN;
      fifo_pkg::PHASE_RUN:   phase_next = fifo_pkg::PHASE_RUN;
      default:               phase_next = fifo_pkg::PHASE_SETUP;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      phase <= fifo_pkg::PHASE_SETUP;
    end else begin
      phase <= phase_next;
    end
  end

  assign running    = (phase == fifo_pkg::PHASE_RUN);
  assign fifo_setup = ~running;

  // Zero destinations are dropped here
  assign fifo_bus.wr_en = fifo_bus.in_valid_reg & (|fifo_bus.in_dest) & running;

  // ----------------------------------------
  // Pop decision
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_q <= '0;
    end else begin
      ready_q <= receiver_ready;
    end
  end

  // Every destined receiver must have been ready last cycle
  assign head_dest      = fifo_bus.head.dest;
  assign all_ready      = ((ready_q & head_dest) == head_dest);
  assign fifo_bus.rd_en = running & ~fifo_bus.empty & all_ready;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= fifo_bus.rd_en;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (fifo_bus.rd_en) begin
      pop_payload <= fifo_bus.head;
    end
  end

  // Push filter upstream keeps zero masks out of the FIFO
  assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_bus.rd_en |-> (fifo_bus.head.dest != '0))
    else $error("response_control: pop with zero destination");

endmodule

`default_nettype wire

// ==== verilog/response_demux.sv ====
// Output stage of the response path
// Fans the popped packet out to the receivers by destination mask

`default_nettype none

module response_demux (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          pop_valid,
  input  engine_pkg::response_payload_t pop_payload,
  output engine_pkg::dest_mask_t        response_out_valid,
  output engine_pkg::response_payload_t response_out_payload
);

  // ----------------------------------------
  // Per receiver valid
  // ----------------------------------------
  // All copies of a packet rise together
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_out_valid <= '0;
    end else begin
      for (int i = 0; i < engine_pkg::NUM_RECEIVERS; i++) begin
        response_out_valid[i] <= pop_valid & pop_payload.dest[i];
      end
    end
  end

  // Shared payload bus for every receiver
  always_ff @(posedge ap_clk) begin
    response_out_payload <= pop_payload;
  end

  // A receiver only sees packets addressed to it
  assert property (@(posedge ap_clk) disable iff (areset_control)
    (response_out_valid & ~response_out_payload.dest) == '0)
    else $error("response_demux: valid outside destination");

endmodule

`default_nettype wire

// ==== verilog/response_engine_top.sv ====
// Response distribution top level
// Input FIFO, control and demux joined by one FIFO interface

`default_nettype none

module response_engine_top (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          response_in_valid,
  input  engine_pkg::response_payload_t response_in_payload,
  input  engine_pkg::dest_mask_t        receiver_ready,
  output engine_pkg::dest_mask_t        response_out_valid,
  output engine_pkg::response_payload_t response_out_payload,
  output logic                          fifo_full,
  output logic                          fifo_prog_full,
  output logic                          fifo_empty,
  output logic                          fifo_setup
);

  logic                          pop_valid;
  engine_pkg::response_payload_t pop_payload;

  response_fifo_if fifo_bus ();

  response_fifo fifo_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (response_in_valid),
    .in_payload     (response_in_payload),
    .fifo_bus       (fifo_bus.fifo)
  );

  response_control control_i (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .receiver_ready (receiver_ready),
    .fifo_bus       (fifo_bus.ctrl),
    .pop_valid      (pop_valid),
    .pop_payload    (pop_payload),
    .fifo_setup     (fifo_setup)
  );

  response_demux demux_i (
    .ap_clk               (ap_clk),
    .areset_control       (areset_control),
    .pop_valid            (pop_valid),
    .pop_payload          (pop_payload),
    .response_out_valid   (response_out_valid),
    .response_out_payload (response_out_payload)
  );

  // FIFO status for the sender
  assign fifo_full      = fifo_bus.full;
  assign fifo_prog_full = fifo_bus.prog_full;
  assign fifo_empty     = fifo_bus.empty;

endmodule

`default_nettype wire

// ==== verilog/response_fifo.sv ====
// Input register and first-word-fall-through response FIFO
// Full, programmable-full, empty and reset-busy flags

`default_nettype none

module response_fifo (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          in_valid,
  input  engine_pkg::response_payload_t in_payload,
  response_fifo_if.fifo                 fifo_bus
);

  engine_pkg::response_packet_t  in_reg;
  engine_pkg::response_payload_t mem [fifo_pkg::FIFO_DEPTH];
  fifo_pkg::fifo_addr_t          wr_ptr;
  fifo_pkg::fifo_addr_t          rd_ptr;
  fifo_pkg::fifo_count_t         count;
  fifo_pkg::rst_cnt_t            busy_cnt;
  logic                          do_wr;
  logic                          do_rd;

  // ----------------------------------------
  // Input register
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_reg.valid <= 1'b0;
    end else begin
      in_reg.valid <= in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_reg.payload <= in_payload;
  end

  // Control filters the push on this destination
  assign fifo_bus.in_valid_reg = in_reg.valid;
  assign fifo_bus.in_dest      = in_reg.payload.dest;

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  // A write into a full FIFO is lost
  assign do_wr = fifo_bus.wr_en & ~fifo_bus.full;
  assign do_rd = fifo_bus.rd_en & ~fifo_bus.empty;

  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= in_reg.payload;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reset-busy countdown, starts once reset is released
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_cnt <= fifo_pkg::rst_cnt_t'(fifo_pkg::RST_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // Head is visible without a read
  assign fifo_bus.head      = mem[rd_ptr];
  assign fifo_bus.empty     = (count == '0);
  assign fifo_bus.full      = (count == fifo_pkg::fifo_count_t'(fifo_pkg::FIFO_DEPTH));
  assign fifo_bus.prog_full = (count >= fifo_pkg::fifo_count_t'(fifo_pkg::PROG_THRESH));
  assign fifo_bus.rst_busy  = (busy_cnt != '0);

  // Sender has to respect prog_full
  assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_bus.wr_en |-> !fifo_bus.full)
    else $error("response_fifo: write while full");

  assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_bus.rd_en |-> !fifo_bus.empty)
    else $error("response_fifo: read while empty");

endmodule

`default_nettype wire

// ==== verilog/response_fifo_if.sv ====
// Interface between the response FIFO and the control module
// Push and pop strobes, head entry, input destination and flags

`default_nettype none

interface response_fifo_if;

  // Driven by control
  logic                          wr_en;
  logic                          rd_en;

  // Driven by the FIFO
  engine_pkg::response_payload_t head;
  engine_pkg::dest_mask_t        in_dest;
  logic                          in_valid_reg;
  logic                          empty;
  logic                          full;
  logic                          prog_full;
  logic                          rst_busy;

  modport fifo (
    input  wr_en, rd_en,
    output head, in_dest, in_valid_reg, empty, full, prog_full, rst_busy
  );

  modport ctrl (
    output wr_en, rd_en,
    input  head, in_dest, in_valid_reg, empty, full, prog_full, rst_busy
  );

endinterface

`default_nettype wire
